/* build.f */
source/event_pkg.sv
source/mem_pkg.sv
source/event_memory.sv
source/mem_arbiter.sv
source/link_accumulator.sv
source/header_writer.sv
source/event_readout.sv
source/event_builder_top.sv
verification/tb_clock_gen.sv
verification/event_builder_asserts.sv
verification/tb_event_builder.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_event_builder
FILELIST  = build.f
OBJ_DIR   = obj_dir

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep "STATUS: PASS" > /dev/null

clean:
	rm -rf $(OBJ_DIR)

/* verification/tb_event_builder.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_event_builder
    import event_pkg::*;
();

    localparam int NUM_SLOTS   = 4;
    localparam int LINK_WORDS  = 8;
    localparam int OUT_CREDITS = 4;
    localparam int PERIOD      = 100;
    localparam int NUM_SEGS    = 16;
    localparam int MAX_EV      = 4;
    // each segment may add a closed window burst on top of its events
    localparam int TIMEOUT_NS  = NUM_SEGS * (MAX_EV + 1) * 200 * PERIOD;

    logic                             aclk;
    logic                             reset_i;
    logic                             event_open_i;
    logic [NUM_LINKS-1:0]             link_mask_i;
    logic [NUM_LINKS-1:0]             link_valid_i;
    logic [NUM_LINKS-1:0]             link_last_i;
    logic [NUM_LINKS-1:0][BEAT_W-1:0] link_data_i;
    logic [NUM_LINKS-1:0]             link_ready_o;
    logic                             out_valid_o;
    logic                             out_last_o;
    logic [WORD_W-1:0]                out_data_o;
    logic                             out_credit_i;

    integer             seed = 32'hf860c3a3;
    // beat queues hold the last flag above the data
    logic [BEAT_W:0]    beat_q [NUM_LINKS][$];
    // expected words hold the last flag above the data
    logic [WORD_W:0]    exp_q [$];
    logic [EVNUM_W-1:0] evnum;
    int                 tb_credits;
    int                 owed;
    int                 credit_rate;

    tb_clock_gen #(.PERIOD(PERIOD), .RESET_CYCLES(2)) u_clk (
        .aclk(aclk), .reset_o(reset_i)
    );

    event_builder_top #(
        .NUM_SLOTS(NUM_SLOTS), .LINK_WORDS(LINK_WORDS), .OUT_CREDITS(OUT_CREDITS)
    ) DUT (
        .aclk(aclk), .reset_i(reset_i), .event_open_i(event_open_i),
        .link_mask_i(link_mask_i), .link_valid_i(link_valid_i), .link_last_i(link_last_i),
        .link_data_i(link_data_i), .link_ready_o(link_ready_o),
        .out_valid_o(out_valid_o), .out_last_o(out_last_o), .out_data_o(out_data_o),
        .out_credit_i(out_credit_i)
    );

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string what, input logic [WORD_W-1:0] actual,
                               input logic [WORD_W-1:0] expected);
        if (actual !== expected) begin
            stop_with_failure($sformatf("FAILED at %0d ns: %s, expected %h, got %h",
                                        $time, what, expected, actual));
        end
    endtask

    // queues the beats of one event and the words it must produce
    task automatic add_event(input logic [NUM_LINKS-1:0] mask);
        logic [BEAT_W-1:0]    beats [$];
        logic [WORD_W:0]      body [$];
        logic [WORD_W-1:0]    hdr;
        logic [NUM_LINKS-1:0] lanes;
        logic [BEAT_W-1:0]    upper;
        int                   n;
        int                   kept;
        int                   words;
        lanes = ~mask;
        hdr   = WORD_W'(evnum) | (WORD_W'(lanes) << EVNUM_W);
        for (int i = 0; i < NUM_LINKS; i++) begin
            n = 1 + int'({$random(seed)} % (2 * LINK_WORDS + 2));
            beats.delete();
            for (int b = 0; b < n; b++) begin
                beats.push_back($random(seed));
                beat_q[i].push_back({b == n - 1, beats[b]});
            end
            if (!mask[i]) begin
                kept  = (n > 2 * LINK_WORDS) ? 2 * LINK_WORDS : n;
                words = (kept + 1) / 2;
                hdr   = hdr | (WORD_W'(words) << (EVNUM_W + NUM_LINKS + i * LEN_W));
                for (int w = 0; w < words; w++) begin
                    upper = (2 * w + 1 < kept) ? beats[2 * w + 1] : BEAT_W'(0);
                    body.push_back({1'b0, upper, beats[2 * w]});
                end
            end
        end
        if (body.size() == 0) begin
            exp_q.push_back({1'b1, hdr});
        end else begin
            body[body.size() - 1][WORD_W] = 1'b1;
            exp_q.push_back({1'b0, hdr});
            foreach (body[k]) begin
                exp_q.push_back(body[k]);
            end
        end
        evnum++;
    endtask

    function automatic int pending_beats();
        int total;
        total = 0;
        for (int i = 0; i < NUM_LINKS; i++) begin
            total += beat_q[i].size();
        end
        return total;
    endfunction

    task automatic drain();
        while (pending_beats() != 0 || exp_q.size() != 0) begin
            @(negedge aclk);
        end
        repeat (6) @(negedge aclk);
    endtask

    // link driver, output monitor and credit return share one loop
    initial begin : link_driver
        logic [WORD_W:0] exp;
        forever begin
            @(negedge aclk);
            for (int i = 0; i < NUM_LINKS; i++) begin
                if (!reset_i && (!event_open_i || link_mask_i[i])) begin
                    check_value($sformatf("ready of discarding link %0d", i),
                                WORD_W'(link_ready_o[i]), WORD_W'(1));
                end
                if (link_valid_i[i] && link_ready_o[i]) begin
                    void'(beat_q[i].pop_front());
                end
            end
            if (out_valid_o) begin
                if (exp_q.size() == 0) begin
                    stop_with_failure("an output word appeared with no event expected");
                end
                if (tb_credits == 0) begin
                    stop_with_failure("an output word was sent without an output credit");
                end
                exp = exp_q.pop_front();
                check_value("out_data_o", out_data_o, exp[WORD_W-1:0]);
                check_value("out_last_o", WORD_W'(out_last_o), WORD_W'(exp[WORD_W]));
                tb_credits--;
                owed++;
            end
            @(posedge aclk);
            #1;
            if (out_credit_i) begin
                tb_credits++;
            end
            out_credit_i = 1'b0;
            if (owed > 0 && ({$random(seed)} % 4) < credit_rate) begin
                out_credit_i = 1'b1;
                owed--;
            end
            for (int i = 0; i < NUM_LINKS; i++) begin
                if (beat_q[i].size() != 0 && ({$random(seed)} % 4) != 0) begin
                    link_valid_i[i] = 1'b1;
                    link_last_i[i]  = beat_q[i][0][BEAT_W];
                    link_data_i[i]  = beat_q[i][0][BEAT_W-1:0];
                end else begin
                    link_valid_i[i] = 1'b0;
                    link_last_i[i]  = 1'b0;
                    link_data_i[i]  = '0;
                end
            end
        end
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("watchdog timeout: the planned events did not all come out in time");
        $display("STATUS: FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin : main_sequence
        logic [NUM_LINKS-1:0] mask;
        int                   nev;
        event_open_i = 1'b0;
        link_mask_i  = '0;
        link_valid_i = '0;
        link_last_i  = '0;
        link_data_i  = '0;
        out_credit_i = 1'b0;
        evnum        = '0;
        tb_credits   = OUT_CREDITS;
        owed         = 0;
        credit_rate  = 3;
        while (reset_i !== 1'b0) begin
            @(posedge aclk);
        end
        // idle output after reset
        repeat (10) begin
            @(negedge aclk);
            check_value("out_valid_o after reset", WORD_W'(out_valid_o), '0);
        end
        for (int seg = 0; seg < NUM_SEGS; seg++) begin
            if (seg % 4 == 1) begin
                // beats with the window closed are dropped and make no event
                @(posedge aclk);
                #1;
                event_open_i = 1'b0;
                @(negedge aclk);
                add_event('0);
                evnum--;
                exp_q.delete();
                drain();
            end
            mask = $random(seed) & $random(seed);
            if (&mask) begin
                mask[0] = 1'b0;
            end
            nev         = 1 + int'({$random(seed)} % MAX_EV);
            credit_rate = (seg % 3 == 2) ? 1 : 3;
            @(posedge aclk);
            #1;
            link_mask_i  = mask;
            event_open_i = 1'b1;
            @(negedge aclk);
            repeat (nev) add_event(mask);
            drain();
        end
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* verification/event_builder_asserts.sv */
`timescale 1ns/10ps
`default_nettype none

module event_builder_asserts
    import mem_pkg::*;
(
    input wire               aclk,
    input wire               reset_i,
    input wire               out_valid_i,
    input wire               no_credit_i,
    input wire [NUM_REQ-1:0] req_i,
    input wire [NUM_REQ-1:0] grant_i
);

    // a word leaves only against a credit already held
    a_credit_held: assert property (@(posedge aclk) disable iff (reset_i)
        out_valid_i |-> !no_credit_i)
        else $error("output word sent with no output credit");

    a_grant_onehot: assert property (@(posedge aclk) disable iff (reset_i)
        $onehot0(grant_i))
        else $error("more than one memory grant in a cycle");

    // a requester keeps asking until it is granted
    a_req_held: assert property (@(posedge aclk) disable iff (reset_i)
        ($past(req_i & ~grant_i) & ~req_i) == '0)
        else $error("memory request dropped before its grant");

endmodule

bind event_readout event_builder_asserts u_readout_asserts (
    .aclk(aclk), .reset_i(reset_i),
    .out_valid_i(out_valid_o), .no_credit_i(cred_q == '0),
    .req_i('0), .grant_i('0)
);

bind mem_arbiter event_builder_asserts u_arbiter_asserts (
    .aclk(aclk), .reset_i(reset_i),
    .out_valid_i(1'b0), .no_credit_i(1'b0),
    .req_i(req_i), .grant_i(grant_o)
);

`default_nettype wire

/* verification/tb_clock_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 2
) (
    output logic aclk,
    output logic reset_o
);

    initial begin
        aclk = 1'b0;
        forever #(PERIOD / 2) aclk = ~aclk;
    end

    // release lines up with the input drive delay
    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge aclk);
        #1;
        reset_o = 1'b0;
    end

endmodule

`default_nettype wire

/* source/event_builder_top.sv */
`timescale 1ns/10ps
`default_nettype none

module event_builder_top
    import event_pkg::*;
    import mem_pkg::*;
#(
    parameter int NUM_SLOTS   = 4,
    parameter int LINK_WORDS  = 8,
    parameter int OUT_CREDITS = 4
) (
    input  wire                               aclk,
    input  wire                               reset_i,
    input  wire                               event_open_i,
    input  wire [NUM_LINKS-1:0]               link_mask_i,
    input  wire [NUM_LINKS-1:0]               link_valid_i,
    input  wire [NUM_LINKS-1:0]               link_last_i,
    input  wire [NUM_LINKS-1:0][BEAT_W-1:0]   link_data_i,
    output logic [NUM_LINKS-1:0]              link_ready_o,
    output logic                              out_valid_o,
    output logic                              out_last_o,
    output logic [WORD_W-1:0]                 out_data_o,
    input  wire                               out_credit_i
);

    logic [NUM_REQ-1:0]                 req;
    logic [NUM_REQ-1:0]                 we;
    logic [NUM_REQ-1:0]                 grant;
    logic [NUM_REQ-1:0][MEM_ADDR_W-1:0] addr;
    logic [NUM_REQ-1:0][WORD_W-1:0]     wdata;
    logic [NUM_LINKS-1:0]               link_done;
    logic [NUM_LINKS-1:0][LEN_W-1:0]    link_len;
    logic                               slot_free;
    logic                               event_ready;
    logic                               mem_en;
    logic                               mem_we;
    logic [MEM_ADDR_W-1:0]              mem_addr;
    logic [WORD_W-1:0]                  mem_wdata;
    logic [WORD_W-1:0]                  mem_rdata;

    for (genvar i = 0; i < NUM_LINKS; i++) begin : g_link
        assign we[i] = 1'b1;
        link_accumulator #(
            .LINK_IDX(i), .NUM_SLOTS(NUM_SLOTS), .LINK_WORDS(LINK_WORDS)
        ) u_acc (
            .aclk(aclk), .reset_i(reset_i),
            .event_open_i(event_open_i), .link_mask_i(link_mask_i[i]),
            .link_valid_i(link_valid_i[i]), .link_last_i(link_last_i[i]),
            .link_data_i(link_data_i[i]), .link_ready_o(link_ready_o[i]),
            .slot_free_i(slot_free), .event_ready_i(event_ready),
            .mem_req_o(req[i]), .mem_addr_o(addr[i]), .mem_wdata_o(wdata[i]),
            .mem_grant_i(grant[i]),
            .link_done_o(link_done[i]), .link_len_o(link_len[i])
        );
    end

    assign we[REQ_HDR] = 1'b1;

    header_writer #(.NUM_SLOTS(NUM_SLOTS), .LINK_WORDS(LINK_WORDS)) u_hdr (
        .aclk(aclk), .reset_i(reset_i), .event_open_i(event_open_i),
        .link_mask_i(link_mask_i), .link_done_i(link_done), .link_len_i(link_len),
        .slot_free_i(slot_free),
        .mem_req_o(req[REQ_HDR]), .mem_addr_o(addr[REQ_HDR]), .mem_wdata_o(wdata[REQ_HDR]),
        .mem_grant_i(grant[REQ_HDR]), .event_ready_o(event_ready)
    );

    // readout only reads
    assign we[REQ_RD]    = 1'b0;
    assign wdata[REQ_RD] = '0;

    event_readout #(
        .NUM_SLOTS(NUM_SLOTS), .LINK_WORDS(LINK_WORDS), .OUT_CREDITS(OUT_CREDITS)
    ) u_rd (
        .aclk(aclk), .reset_i(reset_i), .event_ready_i(event_ready),
        .mem_req_o(req[REQ_RD]), .mem_addr_o(addr[REQ_RD]), .mem_grant_i(grant[REQ_RD]),
        .mem_rdata_i(mem_rdata), .slot_free_o(slot_free), .out_credit_i(out_credit_i),
        .out_valid_o(out_valid_o), .out_last_o(out_last_o), .out_data_o(out_data_o)
    );

    mem_arbiter u_arb (
        .aclk(aclk), .reset_i(reset_i),
        .req_i(req), .addr_i(addr), .we_i(we), .wdata_i(wdata), .grant_o(grant),
        .mem_en_o(mem_en), .mem_we_o(mem_we), .mem_addr_o(mem_addr), .mem_wdata_o(mem_wdata)
    );

    event_memory u_mem (
        .aclk(aclk), .en_i(mem_en), .we_i(mem_we), .addr_i(mem_addr),
        .wdata_i(mem_wdata), .rdata_o(mem_rdata)
    );

endmodule

`default_nettype wire

/* source/event_readout.sv */
`timescale 1ns/10ps
`default_nettype none

module event_readout
    import event_pkg::*;
    import mem_pkg::*;
#(
    parameter int NUM_SLOTS   = 4,
    parameter int LINK_WORDS  = 8,
    parameter int OUT_CREDITS = 4
) (
    input  wire                   aclk,
    input  wire                   reset_i,
    input  wire                   event_ready_i,
    output logic                  mem_req_o,
    output logic [MEM_ADDR_W-1:0] mem_addr_o,
    input  wire                   mem_grant_i,
    input  wire [WORD_W-1:0]      mem_rdata_i,
    output logic                  slot_free_o,
    input  wire                   out_credit_i,
    output logic                  out_valid_o,
    output logic                  out_last_o,
    output logic [WORD_W-1:0]     out_data_o
);

    localparam int SLOT_SIZE = 1 + NUM_LINKS * LINK_WORDS;
    localparam int SLOT_W    = (NUM_SLOTS > 1) ? $clog2(NUM_SLOTS) : 1;
    localparam int PEND_W    = $clog2(NUM_SLOTS + 1);
    localparam int OCW       = $clog2(OUT_CREDITS + 1);
    localparam int LINK_W    = $clog2(NUM_LINKS);

    localparam logic [1:0] S_IDLE = 2'd0;
    localparam logic [1:0] S_HDR  = 2'd1;
    localparam logic [1:0] S_WAIT = 2'd2;
    localparam logic [1:0] S_BODY = 2'd3;

    logic [1:0]                      state_q;
    logic [PEND_W-1:0]               pend_q;
    logic [OCW-1:0]                  cred_q;
    logic [SLOT_W-1:0]               slot_q;
    logic [NUM_LINKS-1:0][LEN_W-1:0] lens_q;
    logic [LINK_W-1:0]               link_q;
    logic [LEN_W-1:0]                word_q;
    logic                            rvalid_q;
    logic                            hdr_q;
    logic                            last_q;
    logic                            rest_zero;
    logic                            last_word;
    logic                            granted;
    logic                            finish;
    event_word_u                     rword;

    assign rword   = mem_rdata_i;
    assign granted = mem_req_o && mem_grant_i;

    // nothing left in the links after the current one
    always_comb begin
        rest_zero = 1'b1;
        for (int i = 0; i < NUM_LINKS; i++) begin
            if (i > int'(link_q) && lens_q[i] != '0) begin
                rest_zero = 1'b0;
            end
        end
    end

    assign last_word = (word_q + 1'b1 == lens_q[link_q]) && rest_zero;
    assign finish    = (state_q == S_WAIT && rvalid_q && rword.hdr.len == '0)
                       || (state_q == S_BODY && granted && last_word);

    // a read is issued only with a credit left over for it beyond the word in flight
    assign mem_req_o = (cred_q > OCW'(rvalid_q))
                       && (state_q == S_HDR
                           || (state_q == S_BODY && word_q != lens_q[link_q]));
    assign mem_addr_o = MEM_ADDR_W'(int'(slot_q) * SLOT_SIZE + ((state_q == S_HDR) ? 0
                        : 1 + int'(link_q) * LINK_WORDS + int'(word_q)));

    assign out_valid_o = rvalid_q;
    assign out_data_o  = mem_rdata_i;
    assign out_last_o  = rvalid_q && (hdr_q ? (rword.hdr.len == '0) : last_q);

    always_ff @(posedge aclk) begin
        slot_free_o <= 1'b0;
        rvalid_q    <= granted;
        hdr_q       <= state_q == S_HDR;
        last_q      <= state_q == S_BODY && last_word;
        if (reset_i) begin
            state_q  <= S_IDLE;
            pend_q   <= '0;
            cred_q   <= OCW'(OUT_CREDITS);
            slot_q   <= '0;
            rvalid_q <= 1'b0;
        end else begin
            pend_q <= pend_q + PEND_W'(event_ready_i) - PEND_W'(finish);
            cred_q <= cred_q + OCW'(out_credit_i) - OCW'(out_valid_o);
            case (state_q)
                S_IDLE: begin
                    if (pend_q != '0) begin
                        state_q <= S_HDR;
                    end
                end
                S_HDR: begin
                    if (granted) begin
                        state_q <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    if (rvalid_q) begin
                        lens_q  <= rword.hdr.len;
                        link_q  <= '0;
                        word_q  <= '0;
                        state_q <= (rword.hdr.len == '0) ? S_IDLE : S_BODY;
                    end
                end
                default: begin
                    if (word_q == lens_q[link_q]) begin
                        link_q <= link_q + 1'b1;
                        word_q <= '0;
                    end else if (granted) begin
                        word_q <= word_q + 1'b1;
                        if (last_word) begin
                            state_q <= S_IDLE;
                        end
                    end
                end
            endcase
            if (finish) begin
                slot_free_o <= 1'b1;
                slot_q <= (slot_q == SLOT_W'(NUM_SLOTS - 1)) ? '0 : slot_q + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* source/header_writer.sv */
`timescale 1ns/10ps
`default_nettype none

module header_writer
    import event_pkg::*;
    import mem_pkg::*;
#(
    parameter int NUM_SLOTS  = 4,
    parameter int LINK_WORDS = 8
) (
    input  wire                             aclk,
    input  wire                             reset_i,
    input  wire                             event_open_i,
    input  wire [NUM_LINKS-1:0]             link_mask_i,
    input  wire [NUM_LINKS-1:0]             link_done_i,
    input  wire [NUM_LINKS-1:0][LEN_W-1:0]  link_len_i,
    input  wire                             slot_free_i,
    output logic                            mem_req_o,
    output logic [MEM_ADDR_W-1:0]           mem_addr_o,
    output logic [WORD_W-1:0]               mem_wdata_o,
    input  wire                             mem_grant_i,
    output logic                            event_ready_o
);

    localparam int SLOT_SIZE = 1 + NUM_LINKS * LINK_WORDS;
    localparam int SLOT_W    = (NUM_SLOTS > 1) ? $clog2(NUM_SLOTS) : 1;
    localparam int CRED_W    = $clog2(NUM_SLOTS + 1);

    // completions are kept per slot, a fast link may already be a slot ahead
    logic [NUM_SLOTS-1:0][NUM_LINKS-1:0]            done_q;
    logic [NUM_SLOTS-1:0][NUM_LINKS-1:0][LEN_W-1:0] len_q;
    logic [NUM_LINKS-1:0][SLOT_W-1:0]               lptr_q;
    logic [SLOT_W-1:0]                              slot_q;
    logic [CRED_W-1:0]                              credits_q;
    logic [EVNUM_W-1:0]                             evnum_q;
    logic                                           start;
    event_word_u                                    hword;

    // an all masked event needs the open window
    assign start = !mem_req_o && (credits_q != '0) && (&(done_q[slot_q] | link_mask_i))
                   && (event_open_i || (|done_q[slot_q]));

    always_comb begin
        hword.hdr.spare = '0;
        hword.hdr.evnum = evnum_q;
        hword.hdr.lanes = done_q[slot_q];
        for (int i = 0; i < NUM_LINKS; i++) begin
            hword.hdr.len[i] = done_q[slot_q][i] ? len_q[slot_q][i] : '0;
        end
    end

    always_ff @(posedge aclk) begin
        event_ready_o <= 1'b0;
        if (reset_i) begin
            done_q    <= '0;
            lptr_q    <= '0;
            slot_q    <= '0;
            credits_q <= CRED_W'(NUM_SLOTS);
            evnum_q   <= '0;
            mem_req_o <= 1'b0;
        end else begin
            credits_q <= credits_q + CRED_W'(slot_free_i) - CRED_W'(start);
            for (int i = 0; i < NUM_LINKS; i++) begin
                if (link_done_i[i]) begin
                    done_q[lptr_q[i]][i] <= 1'b1;
                    len_q[lptr_q[i]][i]  <= link_len_i[i];
                    lptr_q[i] <= (lptr_q[i] == SLOT_W'(NUM_SLOTS - 1)) ? '0 : lptr_q[i] + 1'b1;
                end
            end
            if (start) begin
                mem_req_o   <= 1'b1;
                mem_addr_o  <= MEM_ADDR_W'(int'(slot_q) * SLOT_SIZE);
                mem_wdata_o <= hword;
            end
            if (mem_req_o && mem_grant_i) begin
                mem_req_o     <= 1'b0;
                event_ready_o <= 1'b1;
                evnum_q       <= evnum_q + 1'b1;
                slot_q <= (slot_q == SLOT_W'(NUM_SLOTS - 1)) ? '0 : slot_q + 1'b1;
                for (int i = 0; i < NUM_LINKS; i++) begin
                    // masked links step past this slot as their accumulators do
                    if (!done_q[slot_q][i]) begin
                        lptr_q[i] <= (lptr_q[i] == SLOT_W'(NUM_SLOTS - 1)) ? '0
                                                                           : lptr_q[i] + 1'b1;
                    end
                    done_q[slot_q][i] <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* source/link_accumulator.sv */
`timescale 1ns/10ps
`default_nettype none

module link_accumulator
    import event_pkg::*;
    import mem_pkg::*;
#(
    parameter int LINK_IDX   = 0,
    parameter int NUM_SLOTS  = 4,
    parameter int LINK_WORDS = 8
) (
    input  wire                   aclk,
    input  wire                   reset_i,
    input  wire                   event_open_i,
    input  wire                   link_mask_i,
    input  wire                   link_valid_i,
    input  wire                   link_last_i,
    input  wire [BEAT_W-1:0]      link_data_i,
    output logic                  link_ready_o,
    input  wire                   slot_free_i,
    input  wire                   event_ready_i,
    output logic                  mem_req_o,
    output logic [MEM_ADDR_W-1:0] mem_addr_o,
    output logic [WORD_W-1:0]     mem_wdata_o,
    input  wire                   mem_grant_i,
    output logic                  link_done_o,
    output logic [LEN_W-1:0]      link_len_o
);

    localparam int SLOT_SIZE = 1 + NUM_LINKS * LINK_WORDS;
    localparam int SLOT_W    = (NUM_SLOTS > 1) ? $clog2(NUM_SLOTS) : 1;
    localparam int CRED_W    = $clog2(NUM_SLOTS + 1);

    logic              active;
    logic              take;
    logic              spend;
    logic              skip;
    logic              full;
    logic              finish;
    logic [SLOT_W-1:0] slot_q;
    logic [CRED_W-1:0] credits_q;
    logic [CRED_W-1:0] ahead_q;
    logic              in_event_q;
    logic              half_q;
    logic [BEAT_W-1:0] lo_q;
    logic [LEN_W-1:0]  wcnt_q;
    logic              fin_q;
    event_word_u       word;

    assign active       = event_open_i && !link_mask_i;
    assign link_ready_o = !active || (!mem_req_o && (in_event_q || credits_q != '0));
    assign take         = active && link_valid_i && link_ready_o;
    assign spend        = take && !in_event_q;
    assign full         = !half_q && (wcnt_q == LEN_W'(LINK_WORDS));
    assign finish       = (take && full && link_last_i) || (mem_req_o && mem_grant_i && fin_q);

    // a header for our current slot without our data means this link sat the event out
    assign skip = event_ready_i && (ahead_q == '0);

    // an odd final beat goes out alone with a zero upper half
    always_comb begin
        word.payload.lo = half_q ? lo_q : link_data_i;
        word.payload.hi = half_q ? link_data_i : '0;
    end

    always_ff @(posedge aclk) begin
        link_done_o <= 1'b0;
        if (reset_i) begin
            slot_q     <= '0;
            credits_q  <= CRED_W'(NUM_SLOTS);
            ahead_q    <= '0;
            in_event_q <= 1'b0;
            half_q     <= 1'b0;
            wcnt_q     <= '0;
            fin_q      <= 1'b0;
            mem_req_o  <= 1'b0;
        end else begin
            credits_q <= credits_q + CRED_W'(slot_free_i) - CRED_W'(spend) - CRED_W'(skip);
            ahead_q   <= ahead_q + CRED_W'(finish) - CRED_W'(event_ready_i && !skip);
            if (spend) begin
                in_event_q <= 1'b1;
            end
            if (take && !full) begin
                if (half_q || link_last_i) begin
                    mem_req_o   <= 1'b1;
                    mem_addr_o  <= MEM_ADDR_W'(int'(slot_q) * SLOT_SIZE + 1
                                               + LINK_IDX * LINK_WORDS + int'(wcnt_q));
                    mem_wdata_o <= word;
                    wcnt_q      <= wcnt_q + 1'b1;
                    half_q      <= 1'b0;
                    fin_q       <= link_last_i;
                end else begin
                    lo_q   <= link_data_i;
                    half_q <= 1'b1;
                end
            end
            if (mem_req_o && mem_grant_i) begin
                mem_req_o <= 1'b0;
            end
            if (finish || skip) begin
                slot_q <= (slot_q == SLOT_W'(NUM_SLOTS - 1)) ? '0 : slot_q + 1'b1;
            end
            if (finish) begin
                link_done_o <= 1'b1;
                link_len_o  <= wcnt_q;
                in_event_q  <= 1'b0;
                wcnt_q      <= '0;
                fin_q       <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* source/mem_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_arbiter
    import event_pkg::*;
    import mem_pkg::*;
(
    input  wire                                aclk,
    input  wire                                reset_i,
    input  wire [NUM_REQ-1:0]                  req_i,
    input  wire [NUM_REQ-1:0][MEM_ADDR_W-1:0]  addr_i,
    input  wire [NUM_REQ-1:0]                  we_i,
    input  wire [NUM_REQ-1:0][WORD_W-1:0]      wdata_i,
    output logic [NUM_REQ-1:0]                 grant_o,
    output logic                               mem_en_o,
    output logic                               mem_we_o,
    output logic [MEM_ADDR_W-1:0]              mem_addr_o,
    output logic [WORD_W-1:0]                  mem_wdata_o
);

    localparam int PTR_W = $clog2(NUM_REQ);

    logic [PTR_W-1:0] last_q;
    logic [PTR_W-1:0] win;
    logic             found;

    // search starts just after the previous winner
    always_comb begin
        int idx;
        found = 1'b0;
        win   = last_q;
        for (int k = 1; k <= NUM_REQ; k++) begin
            idx = (int'(last_q) + k) % NUM_REQ;
            if (!found && req_i[idx]) begin
                found = 1'b1;
                win   = PTR_W'(idx);
            end
        end
    end

    always_comb begin
        grant_o = '0;
        if (found) begin
            grant_o[win] = 1'b1;
        end
    end

    assign mem_en_o    = found;
    assign mem_we_o    = found && we_i[win];
    assign mem_addr_o  = addr_i[win];
    assign mem_wdata_o = wdata_i[win];

    always_ff @(posedge aclk) begin
        if (reset_i) begin
            // requester 0 has priority first
            last_q <= PTR_W'(NUM_REQ - 1);
        end else if (found) begin
            last_q <= win;
        end
    end

endmodule

`default_nettype wire

/* source/event_memory.sv */
`timescale 1ns/10ps
`default_nettype none

module event_memory
    import event_pkg::*;
    import mem_pkg::*;
(
    input  wire                  aclk,
    input  wire                  en_i,
    input  wire                  we_i,
    input  wire [MEM_ADDR_W-1:0] addr_i,
    input  wire [WORD_W-1:0]     wdata_i,
    output logic [WORD_W-1:0]    rdata_o
);

    logic [WORD_W-1:0] mem [2**MEM_ADDR_W];

    // single port, read data registered one cycle after the access
    always_ff @(posedge aclk) begin
        if (en_i) begin
            if (we_i) begin
                mem[addr_i] <= wdata_i;
            end else begin
                rdata_o <= mem[addr_i];
            end
        end
    end

endmodule

`default_nettype wire

/* source/mem_pkg.sv */
`default_nettype none

package mem_pkg;

    // event memory geometry
    localparam int MEM_ADDR_W = 8;

    // arbiter requesters, links 0 to 3 take the low indices
    localparam int NUM_REQ = 6;
    localparam int REQ_HDR = 4;
    localparam int REQ_RD  = 5;

endpackage

`default_nettype wire

/* source/event_pkg.sv */
`default_nettype none

package event_pkg;

    localparam int NUM_LINKS = 4;
    localparam int BEAT_W    = 32;
    localparam int WORD_W    = 64;
    localparam int LEN_W     = 8;
    localparam int EVNUM_W   = 16;

    // one word of the event memory
    // header view: word counts with link 0 lowest, lanes set for links that sent data
    // payload view: earlier beat in the low half
    typedef union packed {
        struct packed {
            logic [WORD_W-EVNUM_W-NUM_LINKS*(LEN_W+1)-1:0] spare;
            logic [NUM_LINKS-1:0][LEN_W-1:0]                len;
            logic [NUM_LINKS-1:0]                           lanes;
            logic [EVNUM_W-1:0]                             evnum;
        } hdr;
        struct packed {
            logic [BEAT_W-1:0] hi;
            logic [BEAT_W-1:0] lo;
        } payload;
    } event_word_u;

endpackage

`default_nettype wire
